/* Bender.yml */
package:
  name: layer_parser

sources:
  - logic/parse_pkg.sv
  - logic/window_ctrl_if.sv
  - logic/window_sequencer.sv
  - logic/bank_capture.sv
  - logic/window_slicer.sv
  - logic/layer_parser.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/layer_parser_assert.sv
      - test/tb_layer_parser.sv

/* all.f */
logic/parse_pkg.sv
logic/window_ctrl_if.sv
logic/window_sequencer.sv
logic/bank_capture.sv
logic/window_slicer.sv
logic/layer_parser.sv
test/tb_clock_gen.sv
test/layer_parser_assert.sv
test/tb_layer_parser.sv

/* logic/bank_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module bank_capture (
	input logic clk,
	input logic rstn,
	input logic en,
	input parse_pkg::bank_word_t bank_data [parse_pkg::n_banks],
	output parse_pkg::bank_word_t words [parse_pkg::n_banks]
);
	import parse_pkg::*;

	////////////////////
	// bank word register
	////////////////////
	// one stage between the RAM outputs and the slicer.
	// holds its words while the walk is paused
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			for (int i = 0; i < n_banks; i++) begin
				words[i] <= '0;
			end
		end else if (en) begin
			for (int i = 0; i < n_banks; i++) begin
				words[i] <= bank_data[i];
			end
		end
	end

endmodule

`default_nettype wire

/* logic/layer_parser.sv */
`timescale 1ns/1ps
`default_nettype none

module layer_parser #(
	parameter int n_cols = 64,
	parameter int n_rows = 64,
	parameter int window_delay = 36, // at least n_slices
	parameter int col_sync = 63
) (
	input logic clk,
	input logic rstn,
	input logic start, // level, low freezes the walk
	output parse_pkg::cs_t bank_cs,
	output parse_pkg::bank_addr_t bank_addr [parse_pkg::n_banks],
	input parse_pkg::bank_word_t bank_data [parse_pkg::n_banks],
	output parse_pkg::lane_t mac_din [parse_pkg::n_banks],
	output logic mac_vld
);
	import parse_pkg::*;

	window_ctrl_if ctrl_if ();

	bank_word_t words [n_banks];
	logic cap_en;

	// capture stops during the pause between rows
	assign cap_en = start && (ctrl_if.kind != col_end);
	assign mac_vld = ctrl_if.slice_en;

	////////////////////
	// sequencer
	////////////////////
	window_sequencer #(
		.n_cols(n_cols),
		.n_rows(n_rows),
		.window_delay(window_delay),
		.col_sync(col_sync)
	) u_seq (
		.clk(clk),
		.rstn(rstn),
		.start(start),
		.bank_cs(bank_cs),
		.bank_addr(bank_addr),
		.ctrl(ctrl_if.producer)
	);

	////////////////////
	// data path
	////////////////////
	bank_capture u_cap (
		.clk(clk),
		.rstn(rstn),
		.en(cap_en),
		.bank_data(bank_data),
		.words(words)
	);

	window_slicer u_slice (
		.clk(clk),
		.rstn(rstn),
		.ctrl(ctrl_if.consumer),
		.words(words),
		.mac_din(mac_din)
	);

endmodule

`default_nettype wire

/* logic/parse_pkg.sv */
`default_nettype none

package parse_pkg;

	////////////////////
	// bank memory geometry
	////////////////////
	localparam int n_banks = 16; // four groups of four
	localparam int bank_w = 128;
	localparam int byte_w = 8;
	localparam int addr_w = 9;
	localparam int half_base = 64; // upper half of a bank
	localparam int n_slices = bank_w / byte_w;

	typedef logic [bank_w-1:0] bank_word_t;
	typedef logic [addr_w-1:0] bank_addr_t;
	typedef logic [byte_w-1:0] lane_t;
	typedef logic [n_banks-1:0] cs_t; // bit i enables bank i

	////////////////////
	// sequencer state
	////////////////////
	typedef enum logic [2:0] {
		idle,
		row_first, // top edge padded
		row_odd,
		row_even,
		row_last, // bottom edge padded
		col_end // pause between rows
	} row_kind_t;

endpackage

`default_nettype wire

/* logic/window_ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface window_ctrl_if;
	import parse_pkg::*;

	row_kind_t kind;
	logic first_col; // left edge
	logic last_col; // right edge
	logic col_toggle; // bank rotation within a group
	logic slice_en;
	logic [$clog2(n_slices)-1:0] slice_idx; // byte within bank word

	modport producer (
		output kind,
		output first_col,
		output last_col,
		output col_toggle,
		output slice_en,
		output slice_idx
	);

	modport consumer (
		input kind,
		input first_col,
		input last_col,
		input col_toggle,
		input slice_en,
		input slice_idx
	);

endinterface

`default_nettype wire

/* logic/window_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module window_sequencer #(
	parameter int n_cols = 64,
	parameter int n_rows = 64,
	parameter int window_delay = 36,
	parameter int col_sync = 63
) (
	input logic clk,
	input logic rstn,
	input logic start,
	output parse_pkg::cs_t bank_cs,
	output parse_pkg::bank_addr_t bank_addr [parse_pkg::n_banks],
	window_ctrl_if.producer ctrl
);
	import parse_pkg::*;

	localparam int col_w = (n_cols > 1) ? $clog2(n_cols) : 1;
	localparam int row_w = (n_rows < 8) ? 3 : $clog2(n_rows + 1); // bit 2 always present
	localparam int cnt_w = $clog2(window_delay + 1);
	localparam int sync_w = $clog2(col_sync + 1);
	localparam int idx_w = $clog2(n_slices);
	localparam int slice_base = window_delay - n_slices + 1; // first sliced count

	row_kind_t state;
	row_kind_t state_nxt;
	logic [row_w-1:0] row;
	logic [row_w-1:0] row_nxt;
	logic [col_w-1:0] col;
	logic [cnt_w-1:0] cnt;
	logic [sync_w-1:0] sync_cnt;
	logic col_toggle;
	logic in_row;
	logic col_step;
	logic row_done;
	logic sync_done;
	logic slice_en;

	// half of group g while row r is read
	function automatic bank_addr_t half_of(input logic [row_w-1:0] r, input int g);
		logic [row_w-1:0] s;
		s = r + row_w'(g);
		return s[2] ? bank_addr_t'(half_base) : '0;
	endfunction

	assign in_row = state inside {row_first, row_odd, row_even, row_last};
	assign col_step = start && in_row && (cnt == cnt_w'(window_delay));
	assign row_done = col_step && (col == col_w'(n_cols - 1));
	assign sync_done = start && (state == col_end) && (sync_cnt == sync_w'(col_sync - 1));
	assign row_nxt = row + 1'b1;

	////////////////////
	// FSM
	////////////////////
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state <= idle;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			idle: begin
				if (start) begin
					state_nxt = row_first;
				end
			end
			col_end: begin
				if (sync_done) begin
					if (row == row_w'(n_rows)) begin
						state_nxt = idle; // frame done
					end else if (row == row_w'(n_rows - 1)) begin
						state_nxt = row_last;
					end else if (row[0]) begin
						state_nxt = row_odd;
					end else begin
						state_nxt = row_even;
					end
				end
			end
			default: begin
				if (row_done) begin
					state_nxt = col_end;
				end
			end
		endcase
	end

	////////////////////
	// position counters
	////////////////////
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			row <= '0;
			col <= '0;
			cnt <= '0;
			col_toggle <= 1'b0;
		end else if (state == idle) begin
			row <= '0;
		end else if (start && in_row) begin
			if (row_done) begin
				cnt <= '0;
				col <= '0;
				col_toggle <= 1'b0;
				row <= row_nxt;
			end else if (col_step) begin
				cnt <= '0;
				col <= col + 1'b1;
				col_toggle <= ~col_toggle;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			sync_cnt <= '0;
		end else if (start && (state == col_end)) begin
			sync_cnt <= sync_done ? '0 : sync_cnt + 1'b1;
		end
	end

	////////////////////
	// bank addresses
	////////////////////
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			for (int i = 0; i < n_banks; i++) begin
				bank_addr[i] <= '0;
			end
		end else if (state == idle) begin
			for (int i = 0; i < n_banks; i++) begin
				bank_addr[i] <= '0; // row 0 sits in the lower halves
			end
		end else if (row_done) begin
			for (int i = 0; i < n_banks; i++) begin
				bank_addr[i] <= half_of(row_nxt, i / 4);
			end
		end else if (col_step) begin
			for (int i = 0; i < n_banks; i++) begin
				if (((i % 4) < 2) == col_toggle) begin
					bank_addr[i] <= bank_addr[i] + 1'b1; // pairs advance in turn
				end
			end
		end
	end

	always_comb begin
		bank_cs = '0;
		if (in_row) begin
			bank_cs = '1;
			if (state == row_first) begin
				bank_cs[n_banks-1 -: 4] = '0; // group 3
			end
			if (state == row_last) begin
				bank_cs[3:0] = '0; // group 0
			end
			if (col == '0) begin
				for (int g = 0; g < n_banks / 4; g++) begin
					bank_cs[4*g+3] = 1'b0;
				end
			end
		end
	end

	assign slice_en = in_row && (cnt >= cnt_w'(slice_base));

	assign ctrl.kind = state;
	assign ctrl.first_col = (col == '0);
	assign ctrl.last_col = (col == col_w'(n_cols - 1));
	assign ctrl.col_toggle = col_toggle;
	assign ctrl.slice_en = slice_en;
	assign ctrl.slice_idx = slice_en ? idx_w'(cnt - cnt_w'(slice_base)) : '0;

endmodule

`default_nettype wire

/* logic/window_slicer.sv */
`timescale 1ns/1ps
`default_nettype none

module window_slicer (
	input logic clk,
	input logic rstn,
	window_ctrl_if.consumer ctrl,
	input parse_pkg::bank_word_t words [parse_pkg::n_banks],
	output parse_pkg::lane_t mac_din [parse_pkg::n_banks]
);
	import parse_pkg::*;

	row_kind_t kind_q;
	logic [1:0] row_mod; // image row mod 4
	logic [1:0] grp [4]; // group feeding window row r
	logic [1:0] bnk [4]; // bank feeding window column c
	logic pad [n_banks];
	lane_t lane_nxt [n_banks];

	////////////////////
	// row tracking
	////////////////////
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			kind_q <= idle;
			row_mod <= '0;
		end else begin
			kind_q <= ctrl.kind;
			if ((ctrl.kind == idle) || (ctrl.kind == row_first)) begin
				row_mod <= '0;
			end else if ((ctrl.kind == col_end) && (kind_q != col_end)) begin
				row_mod <= row_mod + 1'b1; // next row during the pause
			end
		end
	end

	////////////////////
	// rotation and padding
	////////////////////
	always_comb begin
		for (int r = 0; r < 4; r++) begin
			grp[r] = 2'(r) + row_mod;
		end
		for (int c = 0; c < 4; c++) begin
			bnk[c] = 2'(c) + 2'd1 + {1'b0, ctrl.col_toggle};
		end
		for (int r = 0; r < 4; r++) begin
			for (int c = 0; c < 4; c++) begin
				pad[4*r+c] = (ctrl.first_col && (c == 0))
					|| (ctrl.last_col && (c == 3))
					|| ((ctrl.kind == row_first) && (r == 0))
					|| ((ctrl.kind == row_last) && (r == 3));
				lane_nxt[4*r+c] = words[{grp[r], bnk[c]}][ctrl.slice_idx*byte_w +: byte_w];
			end
		end
	end

	// lanes follow slice_en by one cycle
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			for (int i = 0; i < n_banks; i++) begin
				mac_din[i] <= '0;
			end
		end else if (ctrl.slice_en) begin
			for (int i = 0; i < n_banks; i++) begin
				mac_din[i] <= pad[i] ? '0 : lane_nxt[i];
			end
		end
	end

endmodule

`default_nettype wire

/* test/layer_parser_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module layer_parser_assert #(
	parameter int window_delay = 36,
	parameter int col_sync = 63
) (
	input logic clk,
	input logic rstn,
	input logic start,
	input parse_pkg::row_kind_t state,
	input logic [$clog2(window_delay + 1)-1:0] cnt,
	input logic slice_en
);
	import parse_pkg::*;

	localparam int slice_base = window_delay - n_slices + 1; // first sliced count

	int fail_cnt = 0;

	////////////////////
	// MAC valid window
	////////////////////
	vld_opens: assert property (@(posedge clk) disable iff (!rstn)
		$rose(slice_en) |-> (cnt == slice_base))
		else begin
			$error("mac_vld rose away from the first slice of the column");
			fail_cnt++;
		end

	vld_holds: assert property (@(posedge clk) disable iff (!rstn)
		(slice_en && start && (cnt != window_delay)) |=> slice_en)
		else begin
			$error("mac_vld fell before the last slice of the column");
			fail_cnt++;
		end

	vld_closes: assert property (@(posedge clk) disable iff (!rstn)
		(slice_en && start && (cnt == window_delay)) |=> !slice_en)
		else begin
			$error("mac_vld stayed high after the last slice of the column");
			fail_cnt++;
		end

	////////////////////
	// pause between rows
	////////////////////
	// a frozen start only makes the pause longer
	pause_length: assert property (@(posedge clk) disable iff (!rstn)
		$fell(state == col_end) |-> $past(state == col_end, col_sync))
		else begin
			$error("the pause between rows was shorter than col_sync cycles");
			fail_cnt++;
		end

endmodule

bind window_sequencer layer_parser_assert #(
	.window_delay(window_delay),
	.col_sync(col_sync)
) u_assert (
	.clk(clk),
	.rstn(rstn),
	.start(start),
	.state(state),
	.cnt(cnt),
	.slice_en(slice_en)
);

`default_nettype wire

/* test/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int period_ns = 40,
	parameter int reset_cycles = 10
) (
	output logic clk,
	output logic rstn
);

	initial begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end

	initial begin
		rstn = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		rstn <= 1'b1; // release on a rising edge
	end

endmodule

`default_nettype wire

/* test/tb_layer_parser.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_layer_parser;
	import parse_pkg::*;

	localparam int n_cols = 4;
	localparam int n_rows = 4;
	localparam int window_delay = 20;
	localparam int col_sync = 6;
	localparam int col_period = window_delay + 1;
	localparam int row_period = n_cols * col_period + col_sync;
	localparam int slice_base = window_delay - n_slices + 1;
	localparam int freeze_len = 8;
	localparam int limit = n_rows * row_period + freeze_len + 50;
	localparam int depth = 2 ** addr_w;
	localparam int n_pts = 10;

	logic clk;
	logic rstn;
	logic start = 1'b0;
	cs_t bank_cs;
	bank_addr_t bank_addr [n_banks];
	bank_word_t bank_data [n_banks] = '{default: '0};
	lane_t mac_din [n_banks];
	logic mac_vld;

	bank_word_t mem [n_banks][depth];
	logic [31:0] lfsr;
	int cyc;
	int tick = 0;

	// checkpoints: row, column, slice
	string pt_name [n_pts] = '{"first_c0", "first_c1", "first_c3", "odd_c0", "odd_c2",
		"odd_c3", "even_c1", "even_c3", "last_c0", "last_c2"};
	int pt_pos [n_pts][3] = '{'{0, 0, 0}, '{0, 1, 3}, '{0, 3, 15}, '{1, 0, 5}, '{1, 2, 7},
		'{1, 3, 11}, '{2, 1, 9}, '{2, 3, 12}, '{3, 0, 1}, '{3, 2, 13}};

	tb_clock_gen #(.period_ns(40), .reset_cycles(10)) u_clk (.clk(clk), .rstn(rstn));

	layer_parser #(
		.n_cols(n_cols),
		.n_rows(n_rows),
		.window_delay(window_delay),
		.col_sync(col_sync)
	) dut0 (
		.clk(clk),
		.rstn(rstn),
		.start(start),
		.bank_cs(bank_cs),
		.bank_addr(bank_addr),
		.bank_data(bank_data),
		.mac_din(mac_din),
		.mac_vld(mac_vld)
	);

	// block RAM model, one cycle read latency
	always @(posedge clk) begin
		for (int i = 0; i < n_banks; i++) begin
			bank_data[i] <= mem[i][bank_addr[i]];
		end
	end

	////////////////////
	// expected values
	////////////////////
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32+x^22+x^2+x+1
	endfunction

	task automatic fill_banks();
		lfsr = 32'h67b3_1b4d;
		for (int b = 0; b < n_banks; b++) begin
			for (int a = 0; a < depth; a++) begin
				for (int k = 0; k < bank_w; k++) begin
					lfsr = lfsr_step(lfsr);
					mem[b][a][k] = lfsr[0];
				end
			end
		end
	endtask

	function automatic row_kind_t row_kind(input int r);
		if (r == 0) begin
			return row_first;
		end else if (r == n_rows - 1) begin
			return row_last;
		end
		return (r % 2) ? row_odd : row_even;
	endfunction

	function automatic cs_t enabled_banks(input int r, input int c);
		cs_t cs;
		cs = '1;
		for (int g = 0; g < 4; g++) begin
			if ((r == 0 && g == 3) || (r == n_rows - 1 && g == 0)) begin
				cs[4*g +: 4] = '0;
			end
			if (c == 0) begin
				cs[4*g+3] = 1'b0; // bank 3 idle in the first column
			end
		end
		return cs;
	endfunction

	function automatic bank_addr_t bank_address(input int r, input int c, input int i);
		int part;
		int half;
		part = ((i % 4) < 2) ? c / 2 : (c + 1) / 2;
		half = (((r + i / 4) >> 2) & 1) ? half_base : 0;
		return bank_addr_t'(half + part);
	endfunction

	function automatic lane_t window_byte(input int r, input int c, input int s, input int i);
		int wr;
		int wc;
		int bank;
		bank_word_t word;
		wr = i / 4;
		wc = i % 4;
		if ((c == 0 && wc == 0) || (c == n_cols - 1 && wc == 3)
				|| (r == 0 && wr == 0) || (r == n_rows - 1 && wr == 3)) begin
			return '0;
		end
		bank = 4 * ((wr + r) % 4) + (wc + 1 + c % 2) % 4;
		word = mem[bank][bank_address(r, c, bank)];
		return word[s*byte_w +: byte_w];
	endfunction

	////////////////////
	// compare tasks
	////////////////////
	task automatic check_cs(input string name, input cs_t exp, input cs_t act);
		if (act !== exp) begin
			$display("Error %s: bank_cs expected %h, got %h", name, exp, act);
			$display("TESTS FAILED");
			$fatal(1, "bank_cs mismatch");
		end
	endtask

	task automatic check_addr(input string name, input bank_addr_t exp, input bank_addr_t act);
		if (act !== exp) begin
			$display("Error %s: bank_addr expected %h, got %h", name, exp, act);
			$display("TESTS FAILED");
			$fatal(1, "bank_addr mismatch");
		end
	endtask

	task automatic check_lane(input string name, input lane_t exp, input lane_t act);
		if (act !== exp) begin
			$display("Error %s: mac_din expected %h, got %h", name, exp, act);
			$display("TESTS FAILED");
			$fatal(1, "mac_din mismatch");
		end
	endtask

	task automatic check_vld(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Error %s: mac_vld expected %b, got %b", name, exp, act);
			$display("TESTS FAILED");
			$fatal(1, "mac_vld mismatch");
		end
	endtask

	task automatic check_kind(input string name, input row_kind_t exp, input row_kind_t act);
		if (act !== exp) begin
			$display("Error %s: state expected %s, got %s", name, exp.name(), act.name());
			$display("TESTS FAILED");
			$fatal(1, "state mismatch");
		end
	endtask

	task automatic step_to(input int pos);
		while (cyc < pos) begin
			@(negedge clk);
			cyc++;
		end
	endtask

	////////////////////
	// watchdog
	////////////////////
	always @(negedge clk) begin
		if (rstn) begin
			tick++;
		end
		if (dut0.u_seq.u_assert.fail_cnt != 0) begin
			$display("TESTS FAILED");
			$fatal(1, "An assertion on the sequencer failed");
		end else if (tick > limit) begin
			$display("TESTS FAILED");
			$fatal(1, "Timeout: the parser did not finish within %0d cycles", limit);
		end
	end

	initial begin
		int r;
		int c;
		int s;
		int pos;
		fill_banks();
		repeat (4) @(negedge clk);
		check_kind("reset", idle, dut0.u_seq.state);
		check_cs("reset", '0, bank_cs);
		check_vld("reset", 1'b0, mac_vld);
		for (int i = 0; i < n_banks; i++) begin
			check_addr($sformatf("reset bank %0d", i), '0, bank_addr[i]);
			check_lane($sformatf("reset lane %0d", i), '0, mac_din[i]);
		end
		wait (rstn === 1'b1);
		@(posedge clk);
		start <= 1'b1;
		@(negedge clk);
		cyc = -1; // row_first begins at the next edge

		for (int p = 0; p < n_pts; p++) begin
			r = pt_pos[p][0];
			c = pt_pos[p][1];
			s = pt_pos[p][2];
			pos = r * row_period + c * col_period + slice_base + s;
			step_to(pos);
			check_kind(pt_name[p], row_kind(r), dut0.u_seq.state);
			check_cs(pt_name[p], enabled_banks(r, c), bank_cs);
			check_vld(pt_name[p], 1'b1, mac_vld);
			for (int i = 0; i < n_banks; i++) begin
				check_addr($sformatf("%s bank %0d", pt_name[p], i),
					bank_address(r, c, i), bank_addr[i]);
			end
			step_to(pos + 1); // lanes trail mac_vld
			for (int i = 0; i < n_banks; i++) begin
				check_lane($sformatf("%s lane %0d", pt_name[p], i),
					window_byte(r, c, s, i), mac_din[i]);
			end
		end

		// hold start low across a pending column step
		@(posedge clk);
		start <= 1'b0;
		repeat (freeze_len) begin
			@(negedge clk);
			for (int i = 0; i < n_banks; i++) begin
				check_addr($sformatf("freeze bank %0d", i), bank_address(r, c, i), bank_addr[i]);
			end
		end
		@(posedge clk);
		start <= 1'b1;
		repeat (2) @(negedge clk);
		for (int i = 0; i < n_banks; i++) begin
			check_addr($sformatf("resume bank %0d", i), bank_address(r, c + 1, i), bank_addr[i]);
		end

		while (dut0.u_seq.state != idle) begin
			@(negedge clk);
		end
		check_cs("done", '0, bank_cs);
		check_vld("done", 1'b0, mac_vld);

		if (dut0.u_seq.u_assert.fail_cnt != 0) begin
			$display("TESTS FAILED");
			$fatal(1, "An assertion on the sequencer failed");
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire
